//--- Bender.yml
package:
  name: fx_subsystem

sources:
  - logic/power_isa_pkg.sv
  - logic/fx_subsystem_pkg.sv
  - logic/apb_host_port.sv
  - logic/d_form_decoder.sv
  - logic/gpr_file.sv
  - logic/fx_unit.sv
  - logic/fx_subsystem.sv
  - target: test
    files:
      - verif/fx_subsystem_checker.sv
      - verif/fx_subsystem_tb.sv

//--- logic/apb_host_port.sv
`timescale 1ns/1ps

module apb_host_port import fx_subsystem_pkg::*; (
	input  logic              clock_i,
	input  logic              rst_n_i,
	// APB slave
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [APB_AW-1:0] paddr_i,
	input  logic [APB_DW-1:0] pwdata_i,
	output logic [APB_DW-1:0] prdata_o,
	output logic              pready_o,
	output logic              pslverr_o,
	// Decoder side
	input  logic              illegal_i,
	output logic              issue_o,
	output logic [APB_DW-1:0] instr_o,
	// Unit state for readback
	input  logic              wb_valid_i,
	input  logic [CR_W-1:0]   cr_i,
	input  logic              ca_i,
	// GPR host port
	input  logic [XLEN-1:0]   gpr_rdata_i,
	output logic [GPR_AW-1:0] gpr_raddr_o,
	output logic              gpr_we_o,
	output logic [GPR_AW-1:0] gpr_waddr_o,
	output logic              gpr_whalf_o,
	output logic [APB_DW-1:0] gpr_wdata_o
);

	logic access;
	logic hit_instr, hit_cr, hit_xer, hit_gpr;
	logic gpr_wr_access;
	logic stall;
	logic stall_q;  // Last cycle was a stalled GPR write
	logic done;
	logic err;

	////////////////////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////////////////////

	assign access    = psel_i & penable_i;
	assign hit_instr = (paddr_i == ADDR_INSTR);
	assign hit_cr    = (paddr_i == ADDR_CR);
	assign hit_xer   = (paddr_i == ADDR_XER);
	// Word aligned, inside 0x100..0x1FF
	assign hit_gpr   = (paddr_i[APB_AW-1:GPR_OFF_W] == GPR_BASE[APB_AW-1:GPR_OFF_W])
		&& (paddr_i[1:0] == 2'b00);

	// Host GPR write must not meet the writeback in the same cycle
	assign gpr_wr_access = access & pwrite_i & hit_gpr;
	assign stall         = gpr_wr_access & wb_valid_i & ~stall_q;
	assign pready_o      = ~stall;
	assign done          = access & pready_o;

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			stall_q <= 1'b0;
		end else begin
			stall_q <= stall; // At most one wait state
		end
	end

	// Error cases, flagged only at completion
	always_comb begin
		err = 1'b0;
		if (hit_instr) begin
			err = pwrite_i ? illegal_i : 1'b1; // Bad opcode or read of write-only
		end else if (hit_cr || hit_xer) begin
			err = pwrite_i;
		end else if (!hit_gpr) begin
			err = 1'b1;                        // Unmapped
		end
	end
	assign pslverr_o = done & err;

	// Instruction issue
	assign instr_o = pwdata_i;
	assign issue_o = done & pwrite_i & hit_instr & ~illegal_i;

	// GPR write request, one 32-bit half at a time
	assign gpr_raddr_o = paddr_i[GPR_OFF_W-1:3];
	assign gpr_we_o    = done & gpr_wr_access;
	assign gpr_waddr_o = paddr_i[GPR_OFF_W-1:3];
	assign gpr_whalf_o = paddr_i[2];  // 1 selects bits 63:32
	assign gpr_wdata_o = pwdata_i;

	////////////////////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		prdata_o = '0;
		if (hit_gpr) begin
			prdata_o = paddr_i[2] ? gpr_rdata_i[XLEN-1:APB_DW] : gpr_rdata_i[APB_DW-1:0];
		end else if (hit_cr) begin
			prdata_o = cr_i;
		end else if (hit_xer) begin
			prdata_o[XER_CA_BIT] = ca_i; // SO, OV and the rest stay 0
		end
	end

endmodule

//--- logic/d_form_decoder.sv
`timescale 1ns/1ps

module d_form_decoder import fx_subsystem_pkg::*, power_isa_pkg::*; (
	input  logic [INSTR_W-1:0] instr_i,
	input  logic [XLEN-1:0]    gpr_rdata_i,
	output logic [GPR_AW-1:0]  gpr_raddr_o,
	output fx_op_e             op_o,
	output logic               rc_o,
	output logic [GPR_AW-1:0]  dst_o,
	output logic [XLEN-1:0]    operand_o,
	output logic [XLEN-1:0]    imm_o,
	output logic [2:0]         bf_o,
	output logic               is32_o,
	output logic               illegal_o
);

	d_opcode_e         opcd;
	logic [GPR_AW-1:0] rt_rs;
	logic [GPR_AW-1:0] ra;
	logic [IMM_W-1:0]  imm16;
	logic [XLEN-1:0]   imm_ext;
	logic              logical;   // RS is source, RA is target
	logic              shifted;   // Immediate moves up 16 bits
	logic              zext;      // UI rather than SI
	logic              ra_or_zero;

	// Field split
	assign opcd   = d_opcode_e'(instr_i[OPCD_MSB:OPCD_LSB]);
	assign rt_rs  = instr_i[RT_MSB:RT_LSB];
	assign ra     = instr_i[RA_MSB:RA_LSB];
	assign imm16  = instr_i[IMM_MSB:IMM_LSB];
	assign bf_o   = instr_i[BF_MSB:BF_LSB];
	assign is32_o = ~instr_i[L_BIT];

	always_comb begin
		op_o       = OP_NONE;
		rc_o       = 1'b0;
		logical    = 1'b0;
		shifted    = 1'b0;
		zext       = 1'b0;
		ra_or_zero = 1'b0;
		illegal_o  = 1'b0;
		case (opcd)
			MULLI:    op_o = OP_MUL;
			SUBFIC:   op_o = OP_SUBF_CA;
			CMPI:     op_o = OP_CMP;
			CMPLI: begin
				op_o = OP_CMPL;
				zext = 1'b1;
			end
			ADDIC:    op_o = OP_ADD_CA;
			ADDIC_RC: begin
				op_o = OP_ADD_CA;
				rc_o = 1'b1;
			end
			ADDI, ADDIS: begin
				op_o       = OP_ADD;
				shifted    = (opcd == ADDIS);
				ra_or_zero = 1'b1; // RA=0 means literal 0
			end
			ANDI_RC, ANDIS_RC: begin
				op_o    = OP_AND;
				rc_o    = 1'b1;
				logical = 1'b1;
				zext    = 1'b1;
				shifted = (opcd == ANDIS_RC);
			end
			ORI, ORIS: begin
				op_o    = OP_OR;
				logical = 1'b1;
				zext    = 1'b1;
				shifted = (opcd == ORIS);
			end
			XORI, XORIS: begin
				op_o    = OP_XOR;
				logical = 1'b1;
				zext    = 1'b1;
				shifted = (opcd == XORIS);
			end
			default:  illegal_o = 1'b1;
		endcase
	end

	// Immediate extension, then shift for the "is" forms
	assign imm_ext = zext ? {{(XLEN-IMM_W){1'b0}}, imm16} : {{(XLEN-IMM_W){imm16[IMM_W-1]}}, imm16};
	assign imm_o   = shifted ? (imm_ext << IMM_W) : imm_ext;

	// Operand routing
	assign gpr_raddr_o = logical ? rt_rs : ra;
	assign dst_o       = logical ? ra : rt_rs;
	assign operand_o   = (ra_or_zero && (ra == '0)) ? '0 : gpr_rdata_i;

endmodule

//--- logic/fx_subsystem.sv
`timescale 1ns/1ps

module fx_subsystem import fx_subsystem_pkg::*; (
	input  logic              clock_i,
	input  logic              rst_n_i,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [APB_AW-1:0] paddr_i,
	input  logic [APB_DW-1:0] pwdata_i,
	output logic [APB_DW-1:0] prdata_o,
	output logic              pready_o,
	output logic              pslverr_o
);

	// Host port to decoder
	logic              issue, illegal;
	logic [APB_DW-1:0] instr;
	// Decoder to unit
	fx_op_e            op;
	logic              rc, is32;
	logic [GPR_AW-1:0] dst;
	logic [XLEN-1:0]   operand, imm;
	logic [2:0]        bf;
	// GPR ports
	logic [GPR_AW-1:0] dec_raddr, host_raddr, host_waddr, wb_addr;
	logic [XLEN-1:0]   dec_rdata, host_rdata, wb_data;
	logic              host_we, host_whalf, wb_valid;
	logic [APB_DW-1:0] host_wdata;
	// Unit state
	logic [CR_W-1:0]   cr;
	logic              ca;

	apb_host_port apb_host_port_inst (
		.clock_i, .rst_n_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
		.prdata_o, .pready_o, .pslverr_o,
		.illegal_i(illegal), .issue_o(issue), .instr_o(instr),
		.wb_valid_i(wb_valid), .cr_i(cr), .ca_i(ca),
		.gpr_rdata_i(host_rdata), .gpr_raddr_o(host_raddr), .gpr_we_o(host_we),
		.gpr_waddr_o(host_waddr), .gpr_whalf_o(host_whalf), .gpr_wdata_o(host_wdata)
	);

	d_form_decoder d_form_decoder_inst (
		.instr_i(instr), .gpr_rdata_i(dec_rdata), .gpr_raddr_o(dec_raddr),
		.op_o(op), .rc_o(rc), .dst_o(dst), .operand_o(operand), .imm_o(imm),
		.bf_o(bf), .is32_o(is32), .illegal_o(illegal)
	);

	gpr_file gpr_file_inst (
		.clock_i, .rst_n_i,
		.raddr_a_i(dec_raddr), .raddr_b_i(host_raddr),
		.rdata_a_o(dec_rdata), .rdata_b_o(host_rdata),
		.we_i(host_we), .waddr_i(host_waddr), .whalf_i(host_whalf), .wdata_i(host_wdata),
		.wb_valid_i(wb_valid), .wb_addr_i(wb_addr), .wb_data_i(wb_data)
	);

	fx_unit fx_unit_inst (
		.clock_i, .rst_n_i, .issue_i(issue), .op_i(op), .rc_i(rc), .dst_i(dst),
		.operand_i(operand), .imm_i(imm), .bf_i(bf), .is32_i(is32),
		.wb_valid_o(wb_valid), .wb_addr_o(wb_addr), .wb_data_o(wb_data),
		.cr_o(cr), .ca_o(ca)
	);

endmodule

//--- logic/fx_subsystem_pkg.sv
package fx_subsystem_pkg;

	// Data widths
	localparam int XLEN      = 64;
	localparam int NUM_GPR   = 32;
	localparam int GPR_AW    = 5;
	localparam int CR_W      = 32;
	localparam int APB_AW    = 12;
	localparam int APB_DW    = 32;
	localparam int GPR_OFF_W = GPR_AW + 3; // Byte offset bits inside the GPR window

	// Operations of the fixed-point unit
	typedef enum logic [3:0] {
		OP_ADD,
		OP_ADD_CA,  // Add, carry out into CA
		OP_SUBF_CA, // ~RA + imm + 1, carry out into CA
		OP_MUL,
		OP_CMP,
		OP_CMPL,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NONE
	} fx_op_e;

	////////////////////////////////////////////////////////////////////////////
	// APB address map
	////////////////////////////////////////////////////////////////////////////

	localparam logic [APB_AW-1:0] ADDR_INSTR = 12'h000; // Write only
	localparam logic [APB_AW-1:0] ADDR_CR    = 12'h008; // Read only
	localparam logic [APB_AW-1:0] ADDR_XER   = 12'h00C; // Read only
	localparam logic [APB_AW-1:0] GPR_BASE   = 12'h100; // 8 bytes per register
	localparam int                XER_CA_BIT = 29;

endpackage

//--- logic/fx_unit.sv
`timescale 1ns/1ps

module fx_unit import fx_subsystem_pkg::*, power_isa_pkg::*; (
	input  logic              clock_i,
	input  logic              rst_n_i,
	input  logic              issue_i,
	input  fx_op_e            op_i,
	input  logic              rc_i,
	input  logic [GPR_AW-1:0] dst_i,
	input  logic [XLEN-1:0]   operand_i,  // RA, RS or zero, already resolved
	input  logic [XLEN-1:0]   imm_i,      // Extended and shifted
	input  logic [2:0]        bf_i,
	input  logic              is32_i,
	output logic              wb_valid_o,
	output logic [GPR_AW-1:0] wb_addr_o,
	output logic [XLEN-1:0]   wb_data_o,
	output logic [CR_W-1:0]   cr_o,
	output logic              ca_o
);

	// Stage 1 combinational
	logic [XLEN:0]          res_d;   // Bit XLEN is the carry
	logic signed [XLEN-1:0] prod;
	logic [XLEN-1:0]        cmp_a, cmp_b;
	logic                   lt_d, gt_d;
	// Stage 1 registers
	logic                   s1_valid_q;
	fx_op_e                 s1_op_q;
	logic                   s1_rc_q;
	logic [GPR_AW-1:0]      s1_dst_q;
	logic [2:0]             s1_bf_q;
	logic [XLEN:0]          s1_res_q;
	logic                   s1_lt_q, s1_gt_q;
	// Stage 2
	logic                   is_cmp;
	logic                   f_lt, f_gt, f_eq;
	logic [2:0]             fld_idx;
	logic [CR_FIELD_W-1:0]  fld;
	logic [CR_W-1:0]        cr_q;
	logic                   ca_q;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1, arithmetic
	////////////////////////////////////////////////////////////////////////////

	assign prod = $signed(operand_i) * $signed(imm_i); // Low 64 bits only

	always_comb begin
		res_d = '0;
		case (op_i)
			OP_ADD, OP_ADD_CA: res_d = {1'b0, operand_i} + {1'b0, imm_i};
			OP_SUBF_CA:        res_d = {1'b0, ~operand_i} + {1'b0, imm_i} + 1'b1;
			OP_MUL:            res_d = {1'b0, prod};
			OP_AND:            res_d = {1'b0, operand_i & imm_i};
			OP_OR:             res_d = {1'b0, operand_i | imm_i};
			OP_XOR:            res_d = {1'b0, operand_i ^ imm_i};
			default:           res_d = '0;
		endcase
	end

	// Compare relation, low word extended when L=0
	always_comb begin
		cmp_a = operand_i;
		cmp_b = imm_i;
		if (is32_i) begin
			if (op_i == OP_CMP) begin
				cmp_a = {{(XLEN/2){operand_i[XLEN/2-1]}}, operand_i[XLEN/2-1:0]};
				cmp_b = {{(XLEN/2){imm_i[XLEN/2-1]}}, imm_i[XLEN/2-1:0]};
			end else begin
				cmp_a = {{(XLEN/2){1'b0}}, operand_i[XLEN/2-1:0]};
				cmp_b = {{(XLEN/2){1'b0}}, imm_i[XLEN/2-1:0]};
			end
		end
		lt_d = (op_i == OP_CMP) ? ($signed(cmp_a) < $signed(cmp_b)) : (cmp_a < cmp_b);
		gt_d = (op_i == OP_CMP) ? ($signed(cmp_a) > $signed(cmp_b)) : (cmp_a > cmp_b);
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			s1_valid_q <= 1'b0;
		end else begin
			s1_valid_q <= issue_i;  // Captured at E0
		end
	end

	always_ff @(posedge clock_i) begin
		if (issue_i) begin
			s1_op_q  <= op_i;
			s1_rc_q  <= rc_i;
			s1_dst_q <= dst_i;
			s1_bf_q  <= bf_i;
			s1_res_q <= res_d;
			s1_lt_q  <= lt_d;
			s1_gt_q  <= gt_d;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage 2, writeback format and CR/CA
	////////////////////////////////////////////////////////////////////////////

	assign is_cmp = (s1_op_q == OP_CMP) || (s1_op_q == OP_CMPL);

	always_comb begin
		if (is_cmp) begin
			f_lt    = s1_lt_q;
			f_gt    = s1_gt_q;
			f_eq    = ~(s1_lt_q | s1_gt_q);
			fld_idx = s1_bf_q;
		end else begin
			f_lt    = s1_res_q[XLEN-1];  // CR0 from signed result
			f_eq    = (s1_res_q[XLEN-1:0] == '0);
			f_gt    = ~f_lt & ~f_eq;
			fld_idx = '0;
		end
		fld        = '0;
		fld[CR_LT] = f_lt;
		fld[CR_GT] = f_gt;
		fld[CR_EQ] = f_eq;
		fld[CR_SO] = 1'b0;  // No SO tracking
	end

	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_valid_o <= 1'b0;
			cr_q       <= '0;
			ca_q       <= 1'b0;
		end else begin
			wb_valid_o <= s1_valid_q & ~is_cmp;  // Compares write no GPR
			if (s1_valid_q && (s1_rc_q || is_cmp)) begin
				cr_q[CR_W-1-CR_FIELD_W*fld_idx -: CR_FIELD_W] <= fld;
			end
			if (s1_valid_q && ((s1_op_q == OP_ADD_CA) || (s1_op_q == OP_SUBF_CA))) begin
				ca_q <= s1_res_q[XLEN];
			end
		end
	end

	always_ff @(posedge clock_i) begin
		if (s1_valid_q) begin
			wb_addr_o <= s1_dst_q;
			wb_data_o <= s1_res_q[XLEN-1:0];
		end
	end

	assign cr_o = cr_q;
	assign ca_o = ca_q;

endmodule

//--- logic/gpr_file.sv
`timescale 1ns/1ps

module gpr_file import fx_subsystem_pkg::*; (
	input  logic              clock_i,
	input  logic              rst_n_i,
	input  logic [GPR_AW-1:0] raddr_a_i,  // Decoder port
	input  logic [GPR_AW-1:0] raddr_b_i,  // APB port
	output logic [XLEN-1:0]   rdata_a_o,
	output logic [XLEN-1:0]   rdata_b_o,
	// Host half-word writes
	input  logic              we_i,
	input  logic [GPR_AW-1:0] waddr_i,
	input  logic              whalf_i,
	input  logic [APB_DW-1:0] wdata_i,
	// Writeback from the unit
	input  logic              wb_valid_i,
	input  logic [GPR_AW-1:0] wb_addr_i,
	input  logic [XLEN-1:0]   wb_data_i
);

	logic [XLEN-1:0] regs_q [NUM_GPR];

	// Pending writeback wins over stored value
	function automatic logic [XLEN-1:0] read_port(input logic [GPR_AW-1:0] addr);
		if (wb_valid_i && (wb_addr_i == addr)) begin
			return wb_data_i;
		end
		return regs_q[addr];
	endfunction

	always_comb begin
		rdata_a_o = read_port(raddr_a_i);
		rdata_b_o = read_port(raddr_b_i);
	end

	// Host writes are stalled while writeback is pending, never both
	always_ff @(posedge clock_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_GPR; i++) begin
				regs_q[i] <= '0;
			end
		end else if (wb_valid_i) begin
			regs_q[wb_addr_i] <= wb_data_i;
		end else if (we_i) begin
			if (whalf_i) begin
				regs_q[waddr_i][XLEN-1:APB_DW] <= wdata_i;
			end else begin
				regs_q[waddr_i][APB_DW-1:0] <= wdata_i;
			end
		end
	end

endmodule

//--- logic/power_isa_pkg.sv
package power_isa_pkg;

	////////////////////////////////////////////////////////////////////////////
	// D-form primary opcodes
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		MULLI    = 6'd7,  // Multiply low immediate
		SUBFIC   = 6'd8,  // Subtract from immediate carrying
		CMPLI    = 6'd10, // Compare logical immediate
		CMPI     = 6'd11, // Compare immediate
		ADDIC    = 6'd12,
		ADDIC_RC = 6'd13, // addic. with CR0 update
		ADDI     = 6'd14,
		ADDIS    = 6'd15,
		ORI      = 6'd24,
		ORIS     = 6'd25,
		XORI     = 6'd26,
		XORIS    = 6'd27,
		ANDI_RC  = 6'd28, // andi. always records
		ANDIS_RC = 6'd29
	} d_opcode_e;

	////////////////////////////////////////////////////////////////////////////
	// Instruction word fields, little-endian bit numbering
	////////////////////////////////////////////////////////////////////////////

	localparam int INSTR_W  = 32;
	localparam int OPCD_MSB = 31;
	localparam int OPCD_LSB = 26;
	localparam int RT_MSB   = 25; // RT or RS
	localparam int RT_LSB   = 21;
	localparam int RA_MSB   = 20;
	localparam int RA_LSB   = 16;
	localparam int IMM_W    = 16; // SI or UI
	localparam int IMM_MSB  = IMM_W - 1;
	localparam int IMM_LSB  = 0;
	localparam int BF_MSB   = 25; // Compare target field
	localparam int BF_LSB   = 23;
	localparam int L_BIT    = 21; // 0 for 32-bit compare

	// Bit offsets inside one 4-bit CR field, field 0 is CR[31:28]
	localparam int CR_FIELD_W = 4;
	localparam int CR_LT      = 3;
	localparam int CR_GT      = 2;
	localparam int CR_EQ      = 1;
	localparam int CR_SO      = 0;

endpackage

//--- verif/fx_subsystem_checker.sv
`timescale 1ns/1ps

module fx_subsystem_checker import fx_subsystem_pkg::*, power_isa_pkg::*; (
	input  logic              clock_i,
	input  logic              rst_n_i,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [APB_AW-1:0] paddr_i,
	input  logic [APB_DW-1:0] pwdata_i,
	input  logic [APB_DW-1:0] prdata_i,
	input  logic              pready_i,
	input  logic              pslverr_i,
	output int                error_count_o,
	output int                check_count_o
);

	// Architectural state as seen by the host
	logic [XLEN-1:0] gpr_m [NUM_GPR];
	logic [CR_W-1:0] cr_m;
	logic            ca_m;
	// Writeback slot, one and two edges after an issuing transfer
	logic            wb_d1;
	logic            wb_d2;

	////////////////////////////////////////////////////////////////////////////
	// Reference functions
	////////////////////////////////////////////////////////////////////////////

	function automatic logic listed(input logic [5:0] opcd);
		case (opcd)
			MULLI, SUBFIC, CMPLI, CMPI, ADDIC, ADDIC_RC, ADDI, ADDIS: return 1'b1;
			ORI, ORIS, XORI, XORIS, ANDI_RC, ANDIS_RC:                return 1'b1;
			default:                                                  return 1'b0;
		endcase
	endfunction

	// Expected pslverr for one completed transfer
	function automatic logic ref_err(input logic write, input logic [APB_AW-1:0] addr,
			input logic [APB_DW-1:0] wdata);
		if (addr == ADDR_INSTR) begin
			return write ? !listed(wdata[31:26]) : 1'b1;
		end
		if ((addr == ADDR_CR) || (addr == ADDR_XER)) begin
			return write;
		end
		if ((addr >= GPR_BASE) && (addr < GPR_BASE + 8 * NUM_GPR) && (addr[1:0] == 2'b00)) begin
			return 1'b0;
		end
		return 1'b1; // Unmapped or misaligned
	endfunction

	function automatic logic [APB_DW-1:0] ref_read(input logic [APB_AW-1:0] addr);
		logic [XLEN-1:0] r;
		if (addr == ADDR_CR) begin
			return cr_m;
		end
		if (addr == ADDR_XER) begin
			return {2'b00, ca_m, 29'd0}; // Only CA, SO stays 0
		end
		r = gpr_m[addr[GPR_OFF_W-1:3]];
		return addr[2] ? r[63:32] : r[31:0];
	endfunction

	// Result in 63:0, carry in bit 64
	function automatic logic [XLEN:0] ref_result(input logic [31:0] w, input logic [XLEN-1:0] src);
		logic [XLEN-1:0] si;
		logic [XLEN-1:0] ui;
		si = {{48{w[15]}}, w[15:0]};
		ui = {48'd0, w[15:0]};
		case (w[31:26])
			MULLI:           return {1'b0, src * si};       // Low half only
			SUBFIC:          return {(si >= src), si - src}; // No borrow means CA=1
			ADDIC, ADDIC_RC: return {1'b0, src} + {1'b0, si};
			ADDI:            return {1'b0, src + si};
			ADDIS:           return {1'b0, src + (si << 16)};
			ORI:             return {1'b0, src | ui};
			ORIS:            return {1'b0, src | (ui << 16)};
			XORI:            return {1'b0, src ^ ui};
			XORIS:           return {1'b0, src ^ (ui << 16)};
			ANDI_RC:         return {1'b0, src & ui};
			ANDIS_RC:        return {1'b0, src & (ui << 16)};
			default:         return '0;
		endcase
	endfunction

	function automatic logic [3:0] cr0_field(input logic [XLEN-1:0] res);
		logic [3:0] f;
		f = '0;
		if (res[XLEN-1])       f[CR_LT] = 1'b1;
		else if (res == '0)    f[CR_EQ] = 1'b1;
		else                   f[CR_GT] = 1'b1;
		return f;
	endfunction

	// One extra bit lets signed and unsigned share one signed compare
	function automatic logic [3:0] ref_cmp_field(input logic [31:0] w, input logic [XLEN-1:0] a);
		logic signed [XLEN:0] x;
		logic signed [XLEN:0] y;
		logic [3:0]           f;
		if (w[31:26] == CMPI) begin
			x = w[21] ? {a[63], a} : {{33{a[31]}}, a[31:0]};
			y = {{49{w[15]}}, w[15:0]};
		end else begin
			x = w[21] ? {1'b0, a} : {33'd0, a[31:0]};
			y = {49'd0, w[15:0]};
		end
		f = '0;
		if (x < y)      f[CR_LT] = 1'b1;
		else if (x > y) f[CR_GT] = 1'b1;
		else            f[CR_EQ] = 1'b1;
		return f;
	endfunction

	task automatic apply_instr(input logic [31:0] w);
		logic [5:0]      opcd;
		logic [4:0]      rt;
		logic [4:0]      ra;
		logic            logical;
		logic [XLEN-1:0] src;
		logic [XLEN:0]   r;
		int              bf;
		opcd    = w[31:26];
		rt      = w[25:21];
		ra      = w[20:16];
		bf      = w[25:23];
		logical = (opcd >= ORI);  // RS source, RA target
		if ((opcd == CMPI) || (opcd == CMPLI)) begin
			cr_m[CR_W-1-CR_FIELD_W*bf -: CR_FIELD_W] = ref_cmp_field(w, gpr_m[ra]);
		end else begin
			src = logical ? gpr_m[rt] : gpr_m[ra];
			if (((opcd == ADDI) || (opcd == ADDIS)) && (ra == 5'd0)) begin
				src = '0;
			end
			r = ref_result(w, src);
			if (logical) gpr_m[ra] = r[XLEN-1:0];
			else         gpr_m[rt] = r[XLEN-1:0];
			if ((opcd == ADDIC) || (opcd == ADDIC_RC) || (opcd == SUBFIC)) begin
				ca_m = r[XLEN];
			end
			if ((opcd == ADDIC_RC) || (opcd == ANDI_RC) || (opcd == ANDIS_RC)) begin
				cr_m[31:28] = cr0_field(r[XLEN-1:0]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare on every falling edge, wait states and completions
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clock_i) begin : compare
		logic              exp_err;
		logic              exp_ready;
		logic              wb_busy;
		logic [APB_DW-1:0] exp_data;
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_GPR; i++) begin
				gpr_m[i] = '0;
			end
			cr_m          = '0;
			ca_m          = 1'b0;
			wb_d1         = 1'b0;
			wb_d2         = 1'b0;
			error_count_o = 0;
			check_count_o = 0;
		end else begin
			wb_busy = wb_d2;  // Writeback cycle of an instruction two edges back
			wb_d2   = wb_d1;
			wb_d1   = 1'b0;
			exp_err = ref_err(pwrite_i, paddr_i, pwdata_i);
			if (psel_i && penable_i) begin
				// Only a host GPR write meets the writeback
				exp_ready = !(pwrite_i && !exp_err && (paddr_i != ADDR_INSTR) && wb_busy);
				if (pready_i !== exp_ready) begin
					error_count_o++;
					$display("error at %0t: pready %b expected %b, %s addr 0x%03h", $time,
						pready_i, exp_ready, pwrite_i ? "write" : "read", paddr_i);
				end
			end
			if (psel_i && penable_i && pready_i) begin
				check_count_o++;
				exp_data = ref_read(paddr_i);
				if (pslverr_i !== exp_err) begin
					error_count_o++;
					$display("error at %0t: pslverr %b expected %b, %s addr 0x%03h", $time,
						pslverr_i, exp_err, pwrite_i ? "write" : "read", paddr_i);
				end
				if (!pwrite_i && !exp_err && (prdata_i !== exp_data)) begin
					error_count_o++;
					$display("error at %0t: read 0x%03h got 0x%08h expected 0x%08h", $time,
						paddr_i, prdata_i, exp_data);
				end
				// Erroneous transfers leave state alone
				if (pwrite_i && !exp_err) begin
					if (paddr_i == ADDR_INSTR) begin
						apply_instr(pwdata_i);
						wb_d1 = (pwdata_i[31:26] != CMPI) && (pwdata_i[31:26] != CMPLI);
					end else if (paddr_i[2]) begin
						gpr_m[paddr_i[GPR_OFF_W-1:3]][63:32] = pwdata_i;
					end else begin
						gpr_m[paddr_i[GPR_OFF_W-1:3]][31:0] = pwdata_i;
					end
				end
			end
		end
	end

endmodule

//--- verif/fx_subsystem_tb.sv
`timescale 1ns/1ps

module fx_subsystem_tb import fx_subsystem_pkg::*, power_isa_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 10;
	localparam int N_ARITH      = 40;
	localparam int N_LOGIC      = 30;
	localparam int N_CMP        = 30;
	localparam int N_DEP        = 20;
	localparam int N_ERR        = 8;
	localparam int READ_ALL     = 2 * NUM_GPR + 2; // All halves, CR, XER
	localparam int N_XFER       = READ_ALL + (2 * NUM_GPR + READ_ALL) + 4 * N_ARITH
		+ 4 * N_LOGIC + 4 * N_CMP + READ_ALL + 6 * N_DEP + 6 * N_ERR + READ_ALL;
	localparam int TIMEOUT_CYCLES = 20 * N_XFER;

	logic              clock;
	logic              rst_n;
	logic              psel, penable, pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic              pready, pslverr;
	int                error_count, check_count;
	int                cycle_count = 0;
	logic [63:0]       rng_state = 64'd11571;

	d_opcode_e arith_ops [5] = '{ADDI, ADDIS, ADDIC, SUBFIC, MULLI};
	d_opcode_e logic_ops [7] = '{ANDI_RC, ANDIS_RC, ADDIC_RC, ORI, ORIS, XORI, XORIS};
	d_opcode_e dep_ops   [3] = '{ADDIC, SUBFIC, MULLI};  // All read RA as a real register

	fx_subsystem fx_subsystem_inst (
		.clock_i(clock), .rst_n_i(rst_n), .psel_i(psel), .penable_i(penable),
		.pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata),
		.prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
	);

	fx_subsystem_checker fx_subsystem_checker_inst (
		.clock_i(clock), .rst_n_i(rst_n), .psel_i(psel), .penable_i(penable),
		.pwrite_i(pwrite), .paddr_i(paddr), .pwdata_i(pwdata), .prdata_i(prdata),
		.pready_i(pready), .pslverr_i(pslverr),
		.error_count_o(error_count), .check_count_o(check_count)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run still busy after %0d cycles", cycle_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// xorshift64
	function automatic logic [63:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 7;
		rng_state ^= rng_state << 17;
		return rng_state;
	endfunction

	function automatic logic [APB_AW-1:0] gpr_addr(input logic [4:0] r, input logic hi);
		return GPR_BASE + {4'd0, r, hi, 2'b00};
	endfunction

	// Setup then access, holds access until pready seen at a falling edge
	task automatic do_transfer(input logic write, input logic [APB_AW-1:0] addr,
			input logic [APB_DW-1:0] wdata);
		logic ready;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(posedge clock);
		#2;
		penable = 1'b1;
		ready   = 1'b0;
		while (!ready) begin
			@(negedge clock);
			ready = pready;
			@(posedge clock);
			#2;
		end
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic write_word(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
		do_transfer(1'b1, addr, data);
	endtask

	task automatic read_word(input logic [APB_AW-1:0] addr);
		do_transfer(1'b0, addr, '0);
	endtask

	task automatic read_back_all();
		for (int r = 0; r < NUM_GPR; r++) begin
			read_word(gpr_addr(r, 1'b0));
			read_word(gpr_addr(r, 1'b1));
		end
		read_word(ADDR_CR);
		read_word(ADDR_XER);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic [63:0]       r;
		logic [63:0]       val;
		logic [5:0]        opcd;
		logic [4:0]        rt, ra, dst, wr;
		logic [15:0]       imm;
		logic [APB_AW-1:0] bad_addr;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		rst_n   = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		rst_n = 1'b1;

		read_back_all(); // Everything zero out of reset
		for (int i = 0; i < 2 * NUM_GPR; i++) begin
			r = next_rand();
			write_word(gpr_addr(i / 2, i % 2), r[31:0]);
		end
		read_back_all();

		// Arithmetic, every 4th is addi or addis with RA=0
		for (int i = 0; i < N_ARITH; i++) begin
			r    = next_rand();
			opcd = arith_ops[r[39:32] % 5];
			rt   = r[4:0];
			ra   = r[9:5];
			if (i % 4 == 0) begin
				opcd = (i % 8 == 0) ? ADDI : ADDIS;
				ra   = 5'd0;
			end
			write_word(ADDR_INSTR, {opcd, rt, ra, r[31:16]});
			read_word(gpr_addr(rt, 1'b0));
			read_word(gpr_addr(rt, 1'b1));
			read_word(ADDR_XER);
		end

		// Record forms and logicals
		for (int i = 0; i < N_LOGIC; i++) begin
			r    = next_rand();
			opcd = logic_ops[r[39:32] % 7];
			rt   = r[4:0];
			ra   = r[9:5];
			imm  = (i % 5 == 0) ? 16'd0 : r[31:16];  // Zero AND result hits EQ
			dst  = (opcd == ADDIC_RC) ? rt : ra;
			write_word(ADDR_INSTR, {opcd, rt, ra, imm});
			read_word(gpr_addr(dst, 1'b0));
			read_word(gpr_addr(dst, 1'b1));
			read_word(ADDR_CR);
		end

		// Compares, operand preloaded, every 3rd equal to the immediate
		for (int i = 0; i < N_CMP; i++) begin
			r    = next_rand();
			opcd = r[40] ? CMPI : CMPLI;
			ra   = r[8:4];
			imm  = r[31:16];
			val  = (i % 3 == 0) ? {{48{imm[15]}}, imm} : next_rand();
			write_word(gpr_addr(ra, 1'b0), val[31:0]);
			write_word(gpr_addr(ra, 1'b1), val[63:32]);
			write_word(ADDR_INSTR, {opcd, r[2:0], 1'b0, r[3], ra, imm});
			read_word(ADDR_CR);
		end
		read_back_all();  // No GPR touched by a compare

		// Dependent pair, then a host write that meets the writeback
		for (int i = 0; i < N_DEP; i++) begin
			r   = next_rand();
			val = next_rand();
			rt  = r[4:0];
			dst = r[14:10];
			wr  = r[19:15];
			write_word(ADDR_INSTR, {ADDI, rt, r[9:5], r[47:32]});
			write_word(ADDR_INSTR, {dep_ops[r[23:21] % 3], dst, rt, r[63:48]});
			write_word(gpr_addr(wr, r[20]), val[31:0]);
			read_word(gpr_addr(dst, 1'b0));
			read_word(gpr_addr(dst, 1'b1));
			read_word(gpr_addr(wr, r[20]));
		end

		// Error responses
		for (int i = 0; i < N_ERR; i++) begin
			r = next_rand();
			write_word(ADDR_INSTR, {1'b1, r[4:0], r[25:0]}); // Opcodes 32..63 unlisted
			read_word(ADDR_INSTR);
			write_word(ADDR_CR, r[63:32]);
			case (r[41:40])
				2'd0:    bad_addr = 12'h004;
				2'd1:    bad_addr = 12'h010;
				2'd2:    bad_addr = 12'h200 + {4'd0, r[47:42], 2'b00};
				default: bad_addr = GPR_BASE + 12'h001;  // Misaligned GPR
			endcase
			do_transfer(r[50], bad_addr, r[31:0]);
			read_word(ADDR_CR);
			read_word(ADDR_XER);
		end
		read_back_all();

		$display("Transfers checked: %0d of %0d, errors: %0d", check_count, N_XFER,
			error_count);
		if ((error_count == 0) && (check_count == N_XFER)) begin
			$display("Simulation finished: PASS");
		end else begin
			if (check_count != N_XFER) begin
				$display("Not every planned transfer reached the checker");
			end
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

//--- verilog.f
logic/power_isa_pkg.sv
logic/fx_subsystem_pkg.sv
logic/apb_host_port.sv
logic/d_form_decoder.sv
logic/gpr_file.sv
logic/fx_unit.sv
logic/fx_subsystem.sv
verif/fx_subsystem_checker.sv
verif/fx_subsystem_tb.sv
